// File: Bender.yml
package:
  name: ahbsdram

dependencies: {}

sources:
  - sdramPkg.sv
  - ahbPkg.sv
  - sdramRefreshTimer.sv
  - sdramDataPath.sv
  - ahbSdramCtrl.sv
  - ahbSdram.sv
  - target: test
    files:
      - sdramBehavModel.sv
      - tbAhbSdram.sv

// File: ahbPkg.sv
/*
 * AHB-Lite encodings and bus widths used by the SDRAM slave
 */
package ahbPkg;

    localparam int HADDR_W = 32;
    localparam int HDATA_W = 32;

    // HTRANS
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // HRESP, only OKAY is ever returned
    localparam logic HRESP_OKAY = 1'b0;

endpackage

// File: ahbSdram.f
sdramPkg.sv
ahbPkg.sv
sdramRefreshTimer.sv
sdramDataPath.sv
ahbSdramCtrl.sv
ahbSdram.sv
sdramBehavModel.sv
tbAhbSdram.sv

// File: ahbSdram.sv
/*
 * AHB-Lite slave for one x16 SDRAM. Connects the control FSM,
 * the refresh timer and the data path to the bus and memory pins.
 */
module ahbSdram (
    input  logic                            HCLK,
    input  logic                            HRESETn,
    input  logic [ahbPkg::HADDR_W-1:0]      HADDR,
    input  logic                            HSEL,
    input  logic [1:0]                      HTRANS,
    input  logic [ahbPkg::HDATA_W-1:0]      HWDATA,
    input  logic                            HWRITE,
    output logic [ahbPkg::HDATA_W-1:0]      HRDATA,
    output logic                            HREADY,
    output logic                            HRESP,
    output logic                            CKE,
    output logic                            CSn,
    output logic                            RASn,
    output logic                            CASn,
    output logic                            WEn,
    output logic [sdramPkg::ADDR_BITS-1:0]  ADDR,
    output logic [sdramPkg::BA_BITS-1:0]    BA,
    inout  wire  [sdramPkg::DQ_BITS-1:0]    DQ,
    output logic [sdramPkg::DM_BITS-1:0]    DQM
);

    logic timerExpired;
    logic loadPowerUp;
    logic loadRefresh;
    logic latchWrite;
    logic driveLow;
    logic driveHigh;
    logic captureLow;
    logic captureHigh;

    ahbSdramCtrl ctrl (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .HADDR        (HADDR),
        .HSEL         (HSEL),
        .HTRANS       (HTRANS),
        .HWRITE       (HWRITE),
        .HREADY       (HREADY),
        .HRESP        (HRESP),
        .timerExpired (timerExpired),
        .loadPowerUp  (loadPowerUp),
        .loadRefresh  (loadRefresh),
        .latchWrite   (latchWrite),
        .driveLow     (driveLow),
        .driveHigh    (driveHigh),
        .captureLow   (captureLow),
        .captureHigh  (captureHigh),
        .CKE          (CKE),
        .CSn          (CSn),
        .RASn         (RASn),
        .CASn         (CASn),
        .WEn          (WEn),
        .ADDR         (ADDR),
        .BA           (BA),
        .DQM          (DQM)
    );

    sdramRefreshTimer timer (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .loadPowerUp  (loadPowerUp),
        .loadRefresh  (loadRefresh),
        .timerExpired (timerExpired)
    );

    sdramDataPath dataPath (
        .HCLK         (HCLK),
        .HWDATA       (HWDATA),
        .latchWrite   (latchWrite),
        .driveLow     (driveLow),
        .driveHigh    (driveHigh),
        .captureLow   (captureLow),
        .captureHigh  (captureHigh),
        .HRDATA       (HRDATA),
        .DQ           (DQ)
    );

endmodule

// File: ahbSdramCtrl.sv
/*
 * AHB-Lite to SDRAM controller FSM. Runs the power-up sequence, serves
 * single 32-bit reads and writes as two-word bursts with auto precharge,
 * and inserts auto refresh when the refresh timer runs out.
 */
module ahbSdramCtrl (
    input  logic                            HCLK,
    input  logic                            HRESETn,
    input  logic [ahbPkg::HADDR_W-1:0]      HADDR,
    input  logic                            HSEL,
    input  logic [1:0]                      HTRANS,
    input  logic                            HWRITE,
    output logic                            HREADY,
    output logic                            HRESP,
    input  logic                            timerExpired,
    output logic                            loadPowerUp,
    output logic                            loadRefresh,
    output logic                            latchWrite,
    output logic                            driveLow,
    output logic                            driveHigh,
    output logic                            captureLow,
    output logic                            captureHigh,
    output logic                            CKE,
    output logic                            CSn,
    output logic                            RASn,
    output logic                            CASn,
    output logic                            WEn,
    output logic [sdramPkg::ADDR_BITS-1:0]  ADDR,
    output logic [sdramPkg::BA_BITS-1:0]    BA,
    output logic [sdramPkg::DM_BITS-1:0]    DQM
);
    import ahbPkg::*;
    import sdramPkg::*;

    typedef enum logic [4:0] {
        sIdle,          // ready for an AHB request
        sInit0Ncke,     // first state after reset
        sInit1Ncke,     // CKE held low until the timer expires
        sInit2Cke,
        sInit3Nop,
        sInit4PrechAll,
        sInit5Nop,      // tRP
        sInit6AutoRef,
        sInit7Nop,      // tRFC, then next refresh or mode load
        sInit8Lmr,
        sInit9Nop,      // tMRD
        sRead0Act,
        sRead1Nop,      // tRCD
        sRead2Read,
        sRead3Nop,      // CAS wait
        sRead4Rd0,
        sRead5Rd1,
        sRead6Nop,      // row cycle recovery
        sWrite0Act,
        sWrite1Nop,     // tRCD
        sWrite2Wr0,
        sWrite3Wr1,
        sWrite4Nop,     // row cycle recovery
        sAref0AutoRef,
        sAref1Nop       // tRFC
    } stateType;

    stateType state, nextState;

    logic [4:0] delayCnt;
    logic [3:0] repeatCnt;
    logic [4:0] cmd;

    logic [SADDR_BITS-1:0] saddrReg;   // {bank, row, col}
    logic                  writeReg;
    logic                  pending;    // request accepted together with a refresh

    logic needAction;
    logic delayDone;
    logic repeatsDone;

    logic [COL_BITS-1:0] addrCol;
    logic [ROW_BITS-1:0] addrRow;
    logic [BA_BITS-1:0]  addrBank;

    assign needAction  = HSEL && (HTRANS != HTRANS_IDLE);
    assign delayDone   = (delayCnt == '0);
    assign repeatsDone = (repeatCnt == '0);

    assign addrCol  = saddrReg[COL_BITS-1:0];
    assign addrRow  = saddrReg[ROW_BITS+COL_BITS-1:COL_BITS];
    assign addrBank = saddrReg[SADDR_BITS-1:ROW_BITS+COL_BITS];

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= sInit0Ncke;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            sIdle: begin
                if (timerExpired) begin
                    nextState = sAref0AutoRef;   // refresh wins over a new request
                end else if (needAction) begin
                    nextState = HWRITE ? sWrite0Act : sRead0Act;
                end
            end
            sInit0Ncke:     nextState = sInit1Ncke;
            sInit1Ncke:     if (timerExpired) nextState = sInit2Cke;
            sInit2Cke:      nextState = sInit3Nop;
            sInit3Nop:      nextState = sInit4PrechAll;
            sInit4PrechAll: nextState = sInit5Nop;
            sInit5Nop:      if (delayDone) nextState = sInit6AutoRef;
            sInit6AutoRef:  nextState = sInit7Nop;
            sInit7Nop: begin
                if (delayDone) begin
                    nextState = repeatsDone ? sInit8Lmr : sInit6AutoRef;
                end
            end
            sInit8Lmr:      nextState = sInit9Nop;
            sInit9Nop:      if (delayDone) nextState = sIdle;

            sRead0Act:      nextState = sRead1Nop;
            sRead1Nop:      if (delayDone) nextState = sRead2Read;
            sRead2Read:     nextState = (DELAY_tCAS == 0) ? sRead4Rd0 : sRead3Nop;
            sRead3Nop:      if (delayDone) nextState = sRead4Rd0;
            sRead4Rd0:      nextState = sRead5Rd1;
            sRead5Rd1:      nextState = sRead6Nop;
            sRead6Nop:      if (delayDone) nextState = sIdle;

            sWrite0Act:     nextState = sWrite1Nop;
            sWrite1Nop:     if (delayDone) nextState = sWrite2Wr0;
            sWrite2Wr0:     nextState = sWrite3Wr1;
            sWrite3Wr1:     nextState = sWrite4Nop;
            sWrite4Nop:     if (delayDone) nextState = sIdle;

            sAref0AutoRef:  nextState = sAref1Nop;
            sAref1Nop: begin
                if (delayDone) begin
                    if (pending) begin
                        nextState = writeReg ? sWrite0Act : sRead0Act;
                    end else begin
                        nextState = sIdle;
                    end
                end
            end
            default:        nextState = sInit0Ncke;
        endcase
    end

    // short waits and the init refresh count
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            delayCnt  <= '0;
            repeatCnt <= '0;
        end else begin
            case (state)
                sInit4PrechAll: begin
                    delayCnt  <= 5'(DELAY_tRP);
                    repeatCnt <= 4'(COUNT_initAutoRef);
                end
                sInit6AutoRef: begin
                    delayCnt  <= 5'(DELAY_tRFC);
                    repeatCnt <= repeatCnt - 1'b1;
                end
                sInit8Lmr:             delayCnt <= 5'(DELAY_tMRD);
                sRead0Act, sWrite0Act: delayCnt <= 5'(DELAY_tRCD);
                sRead2Read:            delayCnt <= 5'(DELAY_tCAS - 1);
                sRead5Rd1:             delayCnt <= 5'(DELAY_afterREAD);
                sWrite3Wr1:            delayCnt <= 5'(DELAY_afterWRITE);
                sAref0AutoRef:         delayCnt <= 5'(DELAY_tRFC);
                default: begin
                    if (!delayDone) begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // HREADY is high in idle, so any request seen there is accepted
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            pending <= 1'b0;
        end else if (state == sIdle) begin
            pending <= needAction;
        end
    end

    always_ff @(posedge HCLK) begin
        if (state == sIdle && needAction) begin
            saddrReg <= HADDR[SADDR_BITS:1];   // halfword granular
            writeReg <= HWRITE;
        end
    end

    // command, address and bank per state
    always_comb begin
        cmd  = CMD_NOP;
        ADDR = '0;
        BA   = '0;
        case (state)
            sInit0Ncke, sInit1Ncke: cmd = CMD_NOP_NCKE;
            sInit4PrechAll: begin
                cmd  = CMD_PRECHARGEALL;
                ADDR = A10_FLAG;
            end
            sInit6AutoRef, sAref0AutoRef: cmd = CMD_AUTOREFRESH;
            sInit8Lmr: begin
                cmd  = CMD_LOADMODEREG;
                ADDR = SDRAM_MODE;
            end
            sRead0Act, sWrite0Act: begin
                cmd  = CMD_ACTIVE;
                ADDR = ADDR_BITS'(addrRow);
                BA   = addrBank;
            end
            sRead2Read: begin
                cmd  = CMD_READ;
                ADDR = ADDR_BITS'(addrCol) | A10_FLAG;   // auto precharge
                BA   = addrBank;
            end
            sWrite2Wr0: begin
                cmd  = CMD_WRITE;
                ADDR = ADDR_BITS'(addrCol) | A10_FLAG;
                BA   = addrBank;
            end
            default: ;
        endcase
    end

    assign {CKE, CSn, RASn, CASn, WEn} = cmd;
    assign DQM = '0;   // full words only

    assign HREADY = (state == sIdle);
    assign HRESP  = HRESP_OKAY;

    assign loadPowerUp = (state == sInit0Ncke);
    assign loadRefresh = (state == sInit6AutoRef) || (state == sAref0AutoRef);

    // data path strobes
    assign latchWrite  = (state == sWrite0Act);   // HWDATA valid by now
    assign driveLow    = (state == sWrite2Wr0);
    assign driveHigh   = (state == sWrite3Wr1);
    assign captureLow  = (state == sRead4Rd0);
    assign captureHigh = (state == sRead5Rd1);

    // no SDRAM command may go out while the bus sees the slave ready
    readyOnlyOnNop: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        HREADY |-> (cmd == CMD_NOP)
    ) else $error("HREADY high with a command on the SDRAM pins");

    /* CKE drops only under reset, power-down is never used */
    ckeStaysHigh: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !$fell(CKE)
    ) else $error("CKE fell after initialisation");

endmodule

// File: sdramBehavModel.sv
/*
 * Behavioural x16 SDRAM for the testbench. CAS latency 2, bursts of two
 * sequential words, and a check on the ACTIVE to READ/WRITE spacing.
 */
module sdramBehavModel (
    input  logic                            CLK,
    input  logic                            CKE,
    input  logic                            CSn,
    input  logic                            RASn,
    input  logic                            CASn,
    input  logic                            WEn,
    input  logic [sdramPkg::ADDR_BITS-1:0]  ADDR,
    input  logic [sdramPkg::BA_BITS-1:0]    BA,
    input  logic [sdramPkg::DM_BITS-1:0]    DQM,
    inout  wire  [sdramPkg::DQ_BITS-1:0]    DQ,
    output logic                            driving,
    output int                              rcdViolations
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdramPkg::*;

    logic [DQ_BITS-1:0]    mem [logic [SADDR_BITS-1:0]];   // {bank, row, col}
    logic [ROW_BITS-1:0]   openRow [1 << BA_BITS];
    int                    actCycle [1 << BA_BITS];
    int                    cycle = 0;
    logic [4:0]            cmd;
    logic [SADDR_BITS-1:0] burstAddr;
    logic [DQ_BITS-1:0]    dqOut;
    int                    readStage = 0;
    logic                  writeSecond = 1'b0;

    initial begin
        driving = 1'b0;
        rcdViolations = 0;
    end

    assign cmd = {CKE, CSn, RASn, CASn, WEn};
    assign DQ  = driving ? dqOut : {DQ_BITS{1'bz}};

    function automatic logic [DQ_BITS-1:0] fetch(input logic [SADDR_BITS-1:0] a);
        return mem.exists(a) ? mem[a] : {DQ_BITS{1'bx}};
    endfunction

    // byte lanes with DQM high keep their old contents
    function automatic logic [DQ_BITS-1:0] maskedWrite(input logic [SADDR_BITS-1:0] a);
        logic [DQ_BITS-1:0] w;
        w = fetch(a);
        for (int b = 0; b < DM_BITS; b++) begin
            if (!DQM[b]) w[8*b +: 8] = DQ[8*b +: 8];
        end
        return w;
    endfunction

    always @(posedge CLK) begin
        cycle++;
        if (writeSecond) begin
            mem[burstAddr ^ 1] = maskedWrite(burstAddr ^ 1);   // second beat of the column pair
            writeSecond = 1'b0;
        end
        // data valid at the second and third edge after READ
        case (readStage)
            1: begin
                dqOut     <= fetch(burstAddr);
                driving   <= 1'b1;
                readStage = 2;
            end
            2: begin
                dqOut     <= fetch(burstAddr ^ 1);
                readStage = 3;
            end
            3: begin
                driving   <= 1'b0;
                readStage = 0;
            end
            default: ;
        endcase
        if (CKE) begin
            case (cmd)
                CMD_ACTIVE: begin
                    openRow[BA]  = ADDR[ROW_BITS-1:0];
                    actCycle[BA] = cycle;
                end
                CMD_READ, CMD_WRITE: begin
                    if (cycle - actCycle[BA] < DELAY_tRCD + 2) begin
                        $display("model: bank %0d accessed %0d cycles after ACTIVE at %0t ns",
                                 BA, cycle - actCycle[BA], $time);
                        rcdViolations++;
                    end
                    burstAddr = {BA, openRow[BA], ADDR[COL_BITS-1:0]};
                    if (cmd == CMD_READ) begin
                        readStage = 1;
                    end else begin
                        mem[burstAddr] = maskedWrite(burstAddr);   // first beat comes with the command
                        writeSecond = 1'b1;
                    end
                end
                default: ;   // precharge, refresh, mode load need no state here
            endcase
        end
    end

endmodule

// File: sdramDataPath.sv
/*
 * SDRAM data path. Holds the write word, drives its two halves onto DQ
 * in the write cycles and assembles the two read halves into HRDATA.
 */
module sdramDataPath (
    input  logic                          HCLK,
    input  logic [ahbPkg::HDATA_W-1:0]    HWDATA,
    input  logic                          latchWrite,
    input  logic                          driveLow,
    input  logic                          driveHigh,
    input  logic                          captureLow,
    input  logic                          captureHigh,
    output logic [ahbPkg::HDATA_W-1:0]    HRDATA,
    inout  wire  [sdramPkg::DQ_BITS-1:0]  DQ
);
    import ahbPkg::*;
    import sdramPkg::*;

    logic [HDATA_W-1:0] writeData;
    logic [DQ_BITS-1:0] readLow;   // first word of the burst

    always_ff @(posedge HCLK) begin
        if (latchWrite) begin
            writeData <= HWDATA;
        end
    end

    // read burst comes low word first
    always_ff @(posedge HCLK) begin
        if (captureLow) begin
            readLow <= DQ;
        end
        if (captureHigh) begin
            HRDATA <= {DQ, readLow};   // held until next read finishes
        end
    end

    // bus released outside the two write cycles
    assign DQ = driveLow  ? writeData[DQ_BITS-1:0] :
                driveHigh ? writeData[HDATA_W-1:DQ_BITS] :
                            {DQ_BITS{1'bz}};

    // a read must never sample while the DUT owns DQ
    noCaptureWhileDriving: assert property (
        @(posedge HCLK)
        (driveLow || driveHigh) |-> !(captureLow || captureHigh)
    ) else $error("DQ captured while driven by the controller");

    oneDriveStrobe: assert property (
        @(posedge HCLK)
        driveLow |-> !driveHigh
    ) else $error("both DQ halves driven at once");

endmodule

// File: sdramPkg.sv
/*
 * SDRAM device description: x16 geometry, controller wait counts,
 * command pin encodings and the mode register word
 */
package sdramPkg;

    // geometry
    localparam int ROW_BITS   = 13;
    localparam int COL_BITS   = 10;
    localparam int BA_BITS    = 2;
    localparam int DQ_BITS    = 16;   // only x16 parts
    localparam int DM_BITS    = 2;
    localparam int ADDR_BITS  = 13;
    localparam int SADDR_BITS = BA_BITS + ROW_BITS + COL_BITS;  // halfword address {bank, row, col}

    // wait counts, shortened for simulation
    localparam int DELAY_nCKE       = 20;    // CKE low after reset
    localparam int DELAY_tREF       = 200;   // refresh interval
    localparam int DELAY_tRP        = 1;     // >= tRP * fclk - 2
    localparam int DELAY_tRFC       = 7;     // >= tRFC * fclk - 2
    localparam int DELAY_tMRD       = 0;     // >= tMRD * fclk - 2
    localparam int DELAY_tRCD       = 1;     // >= tRCD * fclk - 2
    localparam int DELAY_tCAS       = 1;     // CAS - 1
    localparam int DELAY_afterREAD  = 4;     // covers tRC with auto precharge
    localparam int DELAY_afterWRITE = 5;

    localparam int COUNT_initAutoRef = 2;    // refreshes during init

    // {CKE, CSn, RASn, CASn, WEn}
    localparam logic [4:0] CMD_NOP_NCKE     = 5'b00111;
    localparam logic [4:0] CMD_NOP          = 5'b10111;
    localparam logic [4:0] CMD_PRECHARGEALL = 5'b10010;
    localparam logic [4:0] CMD_AUTOREFRESH  = 5'b10001;
    localparam logic [4:0] CMD_LOADMODEREG  = 5'b10000;
    localparam logic [4:0] CMD_ACTIVE       = 5'b10011;
    localparam logic [4:0] CMD_READ         = 5'b10101;
    localparam logic [4:0] CMD_WRITE        = 5'b10100;

    /* mode register: burst length 2, sequential, CAS latency 2,
       programmed burst for reads and writes */
    localparam logic [ADDR_BITS-1:0] SDRAM_MODE = 13'b0_0000_0010_0001;

    // A10 selects all banks on precharge, auto precharge on read/write
    localparam logic [ADDR_BITS-1:0] A10_FLAG = 13'h0400;

endpackage

// File: sdramRefreshTimer.sv
/*
 * Long down-counter of the SDRAM controller. Times the CKE-low wait
 * after power-up and the interval between auto refreshes.
 */
module sdramRefreshTimer (
    input  logic HCLK,
    input  logic HRESETn,
    input  logic loadPowerUp,
    input  logic loadRefresh,
    output logic timerExpired
);
    import sdramPkg::*;

    logic [24:0] count;

    // zero after reset so nothing is pending until the first load
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            count <= '0;
        end else if (loadPowerUp) begin
            count <= 25'(DELAY_nCKE);
        end else if (loadRefresh) begin
            count <= 25'(DELAY_tREF);
        end else if (count != '0) begin
            count <= count - 1'b1;   // saturates at zero
        end
    end

    assign timerExpired = (count == '0);

    // the controller issues the two loads from disjoint states
    loadsExclusive: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        loadPowerUp |-> !loadRefresh
    ) else $error("power-up and refresh loads requested together");

endmodule

// File: tbAhbSdram.sv
/*
 * Testbench for the AHB-Lite SDRAM slave. A random single-transfer master
 * runs against a behavioural SDRAM, with a scoreboard and pin monitors.
 */
module tbAhbSdram;
    timeunit 1ns;
    timeprecision 100ps;
    import sdramPkg::*;
    import ahbPkg::*;

    localparam int          numTransfers  = 200;
    localparam int          windowWords   = 64;
    localparam logic [31:0] windowBase    = 32'h01A0_3000;
    localparam int          idleStretch   = 3 * DELAY_tREF;
    localparam int          refreshLimit  = DELAY_tREF + DELAY_tRFC + DELAY_afterWRITE + 12;
    localparam int          initCycles    = DELAY_nCKE + 8 + DELAY_tRP
                                            + COUNT_initAutoRef * (DELAY_tRFC + 2) + DELAY_tMRD;
    localparam int          accessWorst   = 2 + (DELAY_tRCD + 1) + 1 + DELAY_tCAS + 2
                                            + (DELAY_afterREAD + 1) + 3;   // plus largest gap
    localparam int          timeoutCycles = 2 * (3 + initCycles + idleStretch
                                            + numTransfers * (accessWorst + DELAY_tRFC + 2));

    logic                 HCLK, HRESETn, HSEL, HWRITE, HREADY, HRESP;
    logic [1:0]           HTRANS;
    logic [HADDR_W-1:0]   HADDR;
    logic [HDATA_W-1:0]   HWDATA, HRDATA;
    logic                 CKE, CSn, RASn, CASn, WEn;
    logic [ADDR_BITS-1:0] ADDR;
    logic [BA_BITS-1:0]   BA;
    logic [DM_BITS-1:0]   DQM;
    wire  [DQ_BITS-1:0]   DQ;
    logic                 modelDriving;
    int                   rcdViolations;

    logic [31:0] shadow [windowWords];   // scoreboard starts x until written
    logic [17:0] initLog [$];            // {cmd, addr} of each init command
    int          errs [5];               // init, data, idle, refresh, bus
    int          cycle = 0;
    int          nckeCycles = 0;
    int          lastRef = -1;
    int          readsChecked = 0;
    logic        inGap = 1'b0;
    logic        prevWrite = 1'b0;
    logic        initDone = 1'b0;

    ahbSdram ahbSdram_inst (.*);

    sdramBehavModel memModel (
        .CLK (HCLK), .CKE (CKE), .CSn (CSn), .RASn (RASn), .CASn (CASn), .WEn (WEn),
        .ADDR (ADDR), .BA (BA), .DQM (DQM), .DQ (DQ),
        .driving (modelDriving), .rcdViolations (rcdViolations)
    );

    initial begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;
    end

    task automatic idlePattern();
        HSEL   = 1'($urandom_range(1));
        HTRANS = HSEL ? HTRANS_IDLE : 2'($urandom);   // BUSY only while deselected
        HADDR  = $urandom;
        HWRITE = 1'($urandom_range(1));
    endtask

    task automatic doTransfer();
        logic        write;
        int          idx;
        logic [31:0] data;
        write  = 1'($urandom_range(1));
        idx    = $urandom_range(windowWords - 1);
        data   = $urandom;
        HSEL   = 1'b1;
        HTRANS = HTRANS_NONSEQ;
        HWRITE = write;
        HADDR  = windowBase + idx * 4;
        while (HREADY !== 1'b1) @(negedge HCLK);   // address phase ends at next edge
        @(negedge HCLK);
        HWDATA = write ? data : $urandom;
        idlePattern();
        while (HREADY !== 1'b1) @(negedge HCLK);
        if (write) begin
            shadow[idx] = data;
        end else if (!$isunknown(shadow[idx])) begin
            readsChecked++;
            assert (HRDATA === shadow[idx]) else begin
                $display("** Error at %0t ns: HRDATA expected %h, got %h",
                         $time, shadow[idx], HRDATA);
                errs[1]++;
            end
        end
    endtask

    task automatic checkInit();
        logic [4:0] expCmd;
        assert (nckeCycles >= DELAY_nCKE) else begin
            $display("** Error at %0t ns: CKE low cycles expected >= %0d, got %0d",
                     $time, DELAY_nCKE, nckeCycles);
            errs[0]++;
        end
        assert (initLog.size() == COUNT_initAutoRef + 2) else begin
            $display("init issued %0d commands instead of %0d before HREADY rose",
                     initLog.size(), COUNT_initAutoRef + 2);
            errs[0]++;
        end
        for (int k = 0; k < initLog.size() && k < COUNT_initAutoRef + 2; k++) begin
            expCmd = (k == 0) ? CMD_PRECHARGEALL :
                     (k == COUNT_initAutoRef + 1) ? CMD_LOADMODEREG : CMD_AUTOREFRESH;
            assert (initLog[k][17:13] == expCmd
                    && (k != 0 || (initLog[k][12:0] & A10_FLAG) != 0)
                    && (expCmd != CMD_LOADMODEREG || initLog[k][12:0] == SDRAM_MODE)) else begin
                $display("** Error at %0t ns: init command %0d {cmd,ADDR} expected %b, got %b",
                         $time, k, expCmd, initLog[k]);
                errs[0]++;
            end
        end
    endtask

    task automatic reportTest(input string name, input int idx);
        $display("%-8s %s (%0d errors)", name, errs[idx] == 0 ? "ok" : "FAIL", errs[idx]);
    endtask

    // pin monitor samples mid-cycle where commands and DQ are stable
    always @(negedge HCLK) begin
        logic [4:0] cmd;
        logic       dutDrives;
        logic       writeCycle;
        cmd = {CKE, CSn, RASn, CASn, WEn};
        cycle++;
        if (HRESETn === 1'b1) begin
            if (!initDone) begin
                if (!CKE) nckeCycles++;
                if (cmd != CMD_NOP && cmd != CMD_NOP_NCKE) initLog.push_back({cmd, ADDR});
                if (HREADY === 1'b1) initDone = 1'b1;
            end
            if (cmd == CMD_AUTOREFRESH) begin
                lastRef = cycle;
            end else if (lastRef >= 0) begin
                assert (cycle - lastRef <= refreshLimit) else begin
                    $display("refresh overdue at %0t ns, %0d cycles without AUTO REFRESH",
                             $time, cycle - lastRef);
                    errs[3]++;
                    lastRef = cycle;   // one report per missed window
                end
            end
            if (inGap) begin
                assert (cmd == CMD_NOP || cmd == CMD_AUTOREFRESH) else begin
                    $display("** Error at %0t ns: command expected NOP or AUTO REFRESH, got %b",
                             $time, cmd);
                    errs[2]++;
                end
            end
            assert (HRESP === HRESP_OKAY) else begin
                $display("** Error at %0t ns: HRESP expected %b, got %b",
                         $time, HRESP_OKAY, HRESP);
                errs[4]++;
            end
            assert (DQM === {DM_BITS{1'b0}}) else begin
                $display("** Error at %0t ns: DQM expected %b, got %b",
                         $time, {DM_BITS{1'b0}}, DQM);
                errs[4]++;
            end
            dutDrives  = !modelDriving && (DQ !== {DQ_BITS{1'bz}});
            writeCycle = (cmd == CMD_WRITE) || prevWrite;   // WRITE plus its second beat
            assert (dutDrives == writeCycle) else begin
                $display("** Error at %0t ns: DQ driven by DUT expected %b, got %b",
                         $time, writeCycle, dutDrives);
                errs[4]++;
            end
            prevWrite = (cmd == CMD_WRITE);
        end
    end

    initial begin
        wait (cycle >= timeoutCycles);
        $display("timeout: run did not finish within %0d cycles", timeoutCycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        int total;
        int clean;
        void'($urandom(86));
        HRESETn = 1'b0;
        HSEL    = 1'b0;
        HTRANS  = HTRANS_IDLE;
        HADDR   = '0;
        HWRITE  = 1'b0;
        HWDATA  = '0;
        repeat (3) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
        while (HREADY !== 1'b1) @(negedge HCLK);
        checkInit();
        reportTest("init", 0);
        inGap = 1'b1;
        repeat (idleStretch) begin   // several refresh intervals with no traffic
            idlePattern();
            @(negedge HCLK);
        end
        for (int i = 0; i < numTransfers; i++) begin
            repeat ($urandom_range(3)) begin
                idlePattern();
                @(negedge HCLK);
            end
            inGap = 1'b0;
            doTransfer();
            inGap = 1'b1;
        end
        reportTest("data", 1);
        reportTest("idle", 2);
        reportTest("refresh", 3);
        assert (rcdViolations == 0) else begin
            $display("SDRAM model saw %0d READ/WRITE commands too soon after ACTIVE",
                     rcdViolations);
            errs[4] += rcdViolations;
        end
        reportTest("bus", 4);
        total = 0;
        clean = 0;
        foreach (errs[k]) begin
            total += errs[k];
            if (errs[k] == 0) clean++;
        end
        $display("summary: %0d of 5 groups clean, %0d reads compared, %0d errors",
                 clean, readsChecked, total);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
